/* src/fetch_pkg.sv */
// Fetch subsystem shared definitions

package fetch_pkg;

    // ------------------------------------------------------------
    // Data and address word
    // ------------------------------------------------------------

    // Instructions, program counters, load addresses and bus data
    typedef logic [31:0] word_t;

    // PC step per fetched instruction
    localparam word_t INSTR_BYTES = 32'd4;

    // Default boot address, overridden from the top level
    localparam word_t RESET_PC_DEFAULT = 32'h0000_0100;

    // Low address bits that are zero for an aligned word
    localparam int unsigned ALIGN_BITS = 2;

    // ------------------------------------------------------------
    // Bus side
    // ------------------------------------------------------------

    // Read data presented to a master that does not own the bus
    localparam word_t BUS_IDLE_WORD = 32'h0000_0000;

endpackage

/* src/load_unit.sv */
// Single-word bus read unit

module load_unit import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rstn_i,
    // Owner side
    input  logic  read_i,
    input  word_t addr_i,
    output logic  valid_o,
    output word_t data_o,
    // Bus master side
    output logic  cyc_o,
    output logic  stb_o,
    output word_t adr_o,
    input  word_t dat_i,
    input  logic  ack_i
);

    typedef enum logic {
        LU_IDLE,
        LU_BUSY
    } lu_state_t;

    lu_state_t state_q;
    logic      keep_q;
    logic      valid_q;
    logic      start;
    word_t     adr_q;
    word_t     data_q;

    // No restart in the valid cycle, owner has not stepped its address yet
    assign start = (state_q == LU_IDLE) && read_i && !valid_q;

    // ------------------------------------------------------------
    // Bus cycle control
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= LU_IDLE;
            keep_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                LU_IDLE: begin
                    if (start) begin
                        state_q <= LU_BUSY;
                        keep_q  <= 1'b1;
                    end
                end
                LU_BUSY: begin
                    // Any drop of read marks the result as stale
                    keep_q <= keep_q & read_i;
                    if (ack_i) begin
                        state_q <= LU_IDLE;
                        valid_q <= keep_q & read_i;
                    end
                end
                default: state_q <= LU_IDLE;
            endcase
        end
    end

    // Address and returned word, payload only
    always_ff @(posedge clk) begin
        if (start)
            adr_q <= addr_i;
        if ((state_q == LU_BUSY) && ack_i)
            data_q <= dat_i;
    end

    assign cyc_o   = (state_q == LU_BUSY);
    assign stb_o   = (state_q == LU_BUSY);
    assign adr_o   = adr_q;
    // Withdrawn request in the result cycle gets no pulse
    assign valid_o = valid_q & read_i;
    assign data_o  = data_q;

    // Address held for the whole strobe
    a_adr_stable: assert property (@(posedge clk) disable iff (!rstn_i)
        stb_o |=> !stb_o || $stable(adr_o));

endmodule

/* src/if_stage.sv */
// Instruction fetch stage

module if_stage import fetch_pkg::*; #(
    parameter word_t RESET_PC = RESET_PC_DEFAULT
) (
    input  logic  clk,
    input  logic  rstn_i,
    input  logic  flush_i,
    input  logic  halt_i,
    // Toward decode
    input  logic  ack_i,
    output logic  valid_o,
    output word_t instr_o,
    output word_t pc_o,
    // Redirect
    input  logic  branch_i,
    input  word_t pc_i,
    // Bus master side
    output logic  cyc_o,
    output logic  stb_o,
    output word_t adr_o,
    input  word_t dat_i,
    input  logic  ack_bus_i
);

    word_t pc_q;
    word_t fetch_pc_q;
    logic  read;
    logic  lu_valid;
    word_t lu_data;

    // Output register toward decode
    logic  out_valid_q;
    logic  out_valid_n;
    word_t out_instr_q;
    word_t out_pc_q;

    // Read while the register frees, dropped on any redirect or halt
    assign read = (!out_valid_q || ack_i) && !flush_i && !halt_i && !branch_i;

    load_unit u_lu (
        .clk     ( clk        ),
        .rstn_i  ( rstn_i     ),
        .read_i  ( read       ),
        .addr_i  ( pc_q       ),
        .valid_o ( lu_valid   ),
        .data_o  ( lu_data    ),
        .cyc_o   ( cyc_o      ),
        .stb_o   ( stb_o      ),
        .adr_o   ( adr_o      ),
        .dat_i   ( dat_i      ),
        .ack_i   ( ack_bus_i  )
    );

    // ------------------------------------------------------------
    // Register next state
    // ------------------------------------------------------------
    always_comb begin
        out_valid_n = out_valid_q & !ack_i;
        if (lu_valid)
            out_valid_n = 1'b1;
        if (flush_i)
            out_valid_n = 1'b0;
    end

    always_ff @(posedge clk or negedge rstn_i) begin
        if (!rstn_i) begin
            out_valid_q <= 1'b0;
            pc_q        <= RESET_PC;
        end else if (!halt_i) begin
            out_valid_q <= out_valid_n;
            if (branch_i || flush_i)
                pc_q <= pc_i;
            else if (lu_valid)
                pc_q <= pc_q + INSTR_BYTES;
        end
    end

    // Fetch address tag, taken while the unit is idle
    always_ff @(posedge clk) begin
        if (read && !cyc_o)
            fetch_pc_q <= pc_q;
        if (lu_valid && !halt_i) begin
            out_instr_q <= lu_data;
            out_pc_q    <= fetch_pc_q;
        end
    end

    assign valid_o = out_valid_q;
    assign instr_o = out_instr_q;
    assign pc_o    = out_pc_q;

    // Held word stays put under back-pressure or halt
    a_hold: assert property (@(posedge clk) disable iff (!rstn_i)
        valid_o && (halt_i || (!ack_i && !flush_i))
        |=> valid_o && $stable(instr_o) && $stable(pc_o));

    // Tag of a delivered word is aligned
    a_align: assert property (@(posedge clk) disable iff (!rstn_i)
        valid_o |-> (pc_o[ALIGN_BITS-1:0] == '0));

endmodule

/* src/data_port.sv */
// Data load port

module data_port import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rstn_i,
    // Load request side
    input  logic  ld_req_i,
    input  word_t ld_addr_i,
    output logic  ld_done_o,
    output logic  ld_busy_o,
    output word_t ld_data_o,
    // Bus master side
    output logic  cyc_o,
    output logic  stb_o,
    output word_t adr_o,
    input  word_t dat_i,
    input  logic  ack_bus_i
);

    logic  busy_q;
    word_t addr_q;
    logic  lu_valid;

    // ------------------------------------------------------------
    // Request capture
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            // Done frees the port next cycle
            if (lu_valid)
                busy_q <= 1'b0;
        end else if (ld_req_i) begin
            busy_q <= 1'b1;
        end
    end

    // Requests while busy are dropped
    always_ff @(posedge clk) begin
        if (ld_req_i && !busy_q)
            addr_q <= ld_addr_i;
    end

    // Read held for the whole load
    load_unit u_lu (
        .clk     ( clk       ),
        .rstn_i  ( rstn_i    ),
        .read_i  ( busy_q    ),
        .addr_i  ( addr_q    ),
        .valid_o ( lu_valid  ),
        .data_o  ( ld_data_o ),
        .cyc_o   ( cyc_o     ),
        .stb_o   ( stb_o     ),
        .adr_o   ( adr_o     ),
        .dat_i   ( dat_i     ),
        .ack_i   ( ack_bus_i )
    );

    assign ld_done_o = lu_valid;
    assign ld_busy_o = busy_q;

    // Done only right after a bus cycle of this busy port
    a_done_busy: assert property (@(posedge clk) disable iff (!rstn_i)
        ld_done_o |-> $past(ld_busy_o && cyc_o));

endmodule

/* src/wb_arbiter.sv */
// Two-master bus arbiter

module wb_arbiter import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rstn_i,
    // Fetch master
    input  logic  cyc_f_i,
    input  logic  stb_f_i,
    input  word_t adr_f_i,
    output word_t dat_f_o,
    output logic  ack_f_o,
    // Data master
    input  logic  cyc_d_i,
    input  logic  stb_d_i,
    input  word_t adr_d_i,
    output word_t dat_d_o,
    output logic  ack_d_o,
    // Shared bus
    output logic  cyc_o,
    output logic  stb_o,
    output word_t adr_o,
    input  word_t dat_i,
    input  logic  ack_i
);

    logic locked_q;
    logic owner_q;
    logic own_cyc;
    logic gnt_d;

    // ------------------------------------------------------------
    // Grant
    // ------------------------------------------------------------

    // Cycle of the last owner (owner_q high means the data master)
    assign own_cyc = owner_q ? cyc_d_i : cyc_f_i;

    // Owner keeps the bus until its cyc falls
    // Otherwise the data master goes first
    assign gnt_d = (locked_q && own_cyc) ? owner_q : cyc_d_i;

    always_ff @(posedge clk or negedge rstn_i) begin
        if (!rstn_i) begin
            locked_q <= 1'b0;
            owner_q  <= 1'b0;
        end else begin
            locked_q <= cyc_o;
            owner_q  <= gnt_d;
        end
    end

    // Request mux
    assign cyc_o = gnt_d ? cyc_d_i : cyc_f_i;
    assign stb_o = gnt_d ? stb_d_i : stb_f_i;
    assign adr_o = gnt_d ? adr_d_i : adr_f_i;

    // Response only to the granted master
    assign ack_d_o = ack_i & gnt_d;
    assign ack_f_o = ack_i & !gnt_d;
    assign dat_d_o = gnt_d ? dat_i : BUS_IDLE_WORD;
    assign dat_f_o = gnt_d ? BUS_IDLE_WORD : dat_i;

    // An ack lands on the master that held the grant for its whole cycle
    a_ack_owner: assert property (@(posedge clk) disable iff (!rstn_i)
        ack_i |-> $stable(gnt_d) && (!ack_f_o || cyc_f_i));

endmodule

/* src/fetch_subsys_top.sv */
// Fetch and load subsystem top level

module fetch_subsys_top import fetch_pkg::*; #(
    parameter word_t RESET_PC = RESET_PC_DEFAULT
) (
    input  logic  clk,
    input  logic  rstn_i,
    // Fetch control and decode side
    input  logic  flush_i,
    input  logic  halt_i,
    input  logic  ack_i,
    input  logic  branch_i,
    input  word_t pc_i,
    output logic  valid_o,
    output word_t instr_o,
    output word_t pc_o,
    // Load port
    input  logic  ld_req_i,
    input  word_t ld_addr_i,
    output logic  ld_done_o,
    output logic  ld_busy_o,
    output word_t ld_data_o,
    // External bus
    output logic  wb_cyc_o,
    output logic  wb_stb_o,
    output word_t wb_adr_o,
    input  word_t wb_dat_i,
    input  logic  wb_ack_i
);

    // ------------------------------------------------------------
    // Master to arbiter wiring
    // ------------------------------------------------------------
    logic  cyc_f, stb_f, ack_f;
    logic  cyc_d, stb_d, ack_d;
    word_t adr_f, dat_f;
    word_t adr_d, dat_d;

    if_stage #(
        .RESET_PC ( RESET_PC )
    ) u_if (
        .clk       ( clk      ),
        .rstn_i    ( rstn_i   ),
        .flush_i   ( flush_i  ),
        .halt_i    ( halt_i   ),
        .ack_i     ( ack_i    ),
        .valid_o   ( valid_o  ),
        .instr_o   ( instr_o  ),
        .pc_o      ( pc_o     ),
        .branch_i  ( branch_i ),
        .pc_i      ( pc_i     ),
        .cyc_o     ( cyc_f    ),
        .stb_o     ( stb_f    ),
        .adr_o     ( adr_f    ),
        .dat_i     ( dat_f    ),
        .ack_bus_i ( ack_f    )
    );

    data_port u_dp (
        .clk       ( clk       ),
        .rstn_i    ( rstn_i    ),
        .ld_req_i  ( ld_req_i  ),
        .ld_addr_i ( ld_addr_i ),
        .ld_done_o ( ld_done_o ),
        .ld_busy_o ( ld_busy_o ),
        .ld_data_o ( ld_data_o ),
        .cyc_o     ( cyc_d     ),
        .stb_o     ( stb_d     ),
        .adr_o     ( adr_d     ),
        .dat_i     ( dat_d     ),
        .ack_bus_i ( ack_d     )
    );

    // Data port wins when both start together
    wb_arbiter u_arb (
        .clk     ( clk      ),
        .rstn_i  ( rstn_i   ),
        .cyc_f_i ( cyc_f    ),
        .stb_f_i ( stb_f    ),
        .adr_f_i ( adr_f    ),
        .dat_f_o ( dat_f    ),
        .ack_f_o ( ack_f    ),
        .cyc_d_i ( cyc_d    ),
        .stb_d_i ( stb_d    ),
        .adr_d_i ( adr_d    ),
        .dat_d_o ( dat_d    ),
        .ack_d_o ( ack_d    ),
        .cyc_o   ( wb_cyc_o ),
        .stb_o   ( wb_stb_o ),
        .adr_o   ( wb_adr_o ),
        .dat_i   ( wb_dat_i ),
        .ack_i   ( wb_ack_i )
    );

endmodule

/* sim/wb_mem_model.sv */
// Read-only bus memory model

module wb_mem_model import fetch_pkg::*; #(
    parameter int SEED = 1
) (
    input  logic  clk,
    input  logic  rstn_i,
    input  logic  cyc_i,
    input  logic  stb_i,
    input  word_t adr_i,
    output word_t dat_o,
    output logic  ack_o
);

    timeunit 1ns;
    timeprecision 100ps;

    integer      seed = SEED;
    logic [31:0] rnd;
    logic        busy_q;
    logic [1:0]  wait_q;

    // Word address rotated left by 7, then xor with a fixed constant
    function automatic word_t stored_word(input word_t adr);
        return {adr[26:2], 2'b00, adr[31:27]} ^ 32'h9e37_79b9;
    endfunction

    // ------------------------------------------------------------
    // Registered ack after 0 to 3 wait states
    // ------------------------------------------------------------
    always @(posedge clk or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
            wait_q <= 2'd0;
            ack_o  <= 1'b0;
            dat_o  <= '0;
        end else begin
            ack_o <= 1'b0;
            if (!cyc_i) begin
                // Master gave up the cycle
                busy_q <= 1'b0;
            end else if (stb_i && !ack_o) begin
                if (!busy_q) begin
                    rnd = $random(seed);
                    if (rnd[1:0] == 2'd0) begin
                        ack_o <= 1'b1;
                        dat_o <= stored_word(adr_i);
                    end else begin
                        busy_q <= 1'b1;
                        wait_q <= rnd[1:0];
                    end
                end else if (wait_q == 2'd1) begin
                    busy_q <= 1'b0;
                    ack_o  <= 1'b1;
                    dat_o  <= stored_word(adr_i);
                end else begin
                    wait_q <= wait_q - 2'd1;
                end
            end
        end
    end

endmodule

/* sim/tb_fetch_subsys.sv */
// Fetch subsystem testbench

module tb_fetch_subsys import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam word_t BOOT_PC  = 32'h0000_2000;
    localparam word_t PC_STEP  = 32'd4;
    localparam int    SEED     = 32'h42a6;
    localparam int    WAIT_MAX = 2000;

    logic  clk;
    logic  rstn;
    logic  flush;
    logic  halt;
    logic  dec_ack;
    logic  branch;
    word_t redirect_pc;
    logic  valid;
    word_t instr;
    word_t pc;
    logic  ld_req;
    word_t ld_addr;
    logic  ld_done;
    logic  ld_busy;
    word_t ld_data;
    logic  wb_cyc;
    logic  wb_stb;
    word_t wb_adr;
    word_t wb_dat;
    logic  wb_ack;

    integer seed;
    int     errors;
    int     checks;
    int     words;
    int     dones;
    int     tests_run;
    int     tests_bad;
    int     err_base;
    bit     aborted;
    word_t  exp_pc;
    bit     load_pending;
    word_t  load_addr;
    // Snapshot of the decode side while halted
    bit     hold_watch;
    logic   hold_valid;
    word_t  hold_instr;
    word_t  hold_pc;

    fetch_subsys_top #(
        .RESET_PC ( BOOT_PC )
    ) uut (
        .clk       ( clk         ),
        .rstn_i    ( rstn        ),
        .flush_i   ( flush       ),
        .halt_i    ( halt        ),
        .ack_i     ( dec_ack     ),
        .branch_i  ( branch      ),
        .pc_i      ( redirect_pc ),
        .valid_o   ( valid       ),
        .instr_o   ( instr       ),
        .pc_o      ( pc          ),
        .ld_req_i  ( ld_req      ),
        .ld_addr_i ( ld_addr     ),
        .ld_done_o ( ld_done     ),
        .ld_busy_o ( ld_busy     ),
        .ld_data_o ( ld_data     ),
        .wb_cyc_o  ( wb_cyc      ),
        .wb_stb_o  ( wb_stb      ),
        .wb_adr_o  ( wb_adr      ),
        .wb_dat_i  ( wb_dat      ),
        .wb_ack_i  ( wb_ack      )
    );

    wb_mem_model #(
        .SEED ( SEED )
    ) u_mem (
        .clk    ( clk    ),
        .rstn_i ( rstn   ),
        .cyc_i  ( wb_cyc ),
        .stb_i  ( wb_stb ),
        .adr_i  ( wb_adr ),
        .dat_o  ( wb_dat ),
        .ack_o  ( wb_ack )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Reference and reporting
    // ------------------------------------------------------------

    // Expected memory word
    // Word address rotated left by 7 and xored with a constant
    function automatic word_t mem_word(input word_t addr);
        word_t wa;
        wa = {2'b00, addr[31:2]};
        return {wa[24:0], wa[31:25]} ^ 32'h9e37_79b9;
    endfunction

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        errors++;
        $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic close_test(input int num, input string name);
        tests_run++;
        if (aborted || errors != err_base)
            tests_bad++;
        if (aborted)
            $display("test %0d %s: stopped by a timeout", num, name);
        else
            $display("test %0d %s: %0d errors, %0d words so far", num, name,
                     errors - err_base, words);
    endtask

    // ------------------------------------------------------------
    // Checker sampling at the falling edge
    // ------------------------------------------------------------
    initial begin
        forever begin
            @(negedge clk);
            if (rstn) begin
                // Word taken by decode at the coming edge
                if (valid && dec_ack && !halt && !flush) begin
                    checks++;
                    words++;
                    assert (pc == exp_pc)
                    else report_mismatch("pc_o", pc, exp_pc);
                    assert (instr == mem_word(exp_pc))
                    else report_mismatch("instr_o", instr, mem_word(exp_pc));
                    exp_pc = exp_pc + PC_STEP;
                end
                // Busy from the cycle after a request until its done
                assert (ld_busy == (load_pending && !ld_req))
                else report_mismatch("ld_busy_o", {31'b0, ld_busy},
                                     {31'b0, load_pending && !ld_req});
                if (ld_done) begin
                    checks++;
                    dones++;
                    assert (load_pending)
                    else begin
                        errors++;
                        $display("t=%0t ld_done_o pulsed with no load outstanding", $time);
                    end
                    assert (!load_pending || ld_data == mem_word(load_addr))
                    else report_mismatch("ld_data_o", ld_data, mem_word(load_addr));
                    load_pending = 1'b0;
                end
                if (hold_watch) begin
                    checks++;
                    assert (valid == hold_valid)
                    else report_mismatch("valid_o", {31'b0, valid}, {31'b0, hold_valid});
                    assert (instr == hold_instr)
                    else report_mismatch("instr_o", instr, hold_instr);
                    assert (pc == hold_pc)
                    else report_mismatch("pc_o", pc, hold_pc);
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------

    // Next drive point 1 ns after the rising edge
    task automatic step;
        @(posedge clk);
        #1;
    endtask

    task automatic set_ack(input bit rnd_ack);
        logic [31:0] r;
        r = $random(seed);
        dec_ack = rnd_ack ? r[0] : 1'b1;
    endtask

    task automatic run_words(input int n, input bit rnd_ack);
        int target;
        int cyc;
        target = words + n;
        cyc = 0;
        while (words < target && cyc < WAIT_MAX) begin
            step;
            set_ack(rnd_ack);
            cyc++;
        end
        if (words < target) begin
            aborted = 1'b1;
            $display("t=%0t timeout waiting for %0d fetched words", $time, n);
        end
    endtask

    // Loads at random moments while the fetch stream keeps running
    task automatic run_loads(input int n_loads, input int n_words);
        logic [31:0] r;
        int issued;
        int target;
        int base;
        int cyc;
        issued = 0;
        target = words + n_words;
        base = dones;
        cyc = 0;
        while ((issued < n_loads || words < target) && cyc < WAIT_MAX) begin
            step;
            set_ack(1'b1);
            ld_req = 1'b0;
            r = $random(seed);
            if (issued < n_loads && !load_pending && !ld_busy && r[1:0] == 2'd0) begin
                ld_addr = $random(seed) & 32'hffff_fffc;
                load_addr = ld_addr;
                load_pending = 1'b1;
                ld_req = 1'b1;
                issued++;
            end
            cyc++;
        end
        step;
        ld_req = 1'b0;
        cyc = 0;
        while (load_pending && cyc < WAIT_MAX) begin
            step;
            cyc++;
        end
        if (load_pending || words < target || issued < n_loads) begin
            aborted = 1'b1;
            $display("t=%0t timeout waiting for loads to finish", $time);
        end
        assert (aborted || dones - base == issued)
        else report_mismatch("ld_done_o count", dones - base, issued);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        int cyc;
        rstn = 1'b0;
        flush = 1'b0;
        halt = 1'b0;
        dec_ack = 1'b0;
        branch = 1'b0;
        redirect_pc = '0;
        ld_req = 1'b0;
        ld_addr = '0;
        seed = SEED;
        errors = 0;
        checks = 0;
        words = 0;
        dones = 0;
        tests_run = 0;
        tests_bad = 0;
        aborted = 1'b0;
        exp_pc = BOOT_PC;
        load_pending = 1'b0;
        hold_watch = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        // Test 1 with steady ack from the boot address
        err_base = errors;
        run_words(40, 1'b0);
        close_test(1, "sequential fetch");

        // Test 2 under random decode back-pressure
        if (!aborted) begin
            err_base = errors;
            run_words(60, 1'b1);
            close_test(2, "back-pressure");
        end

        // Test 3 flushes to random aligned targets
        if (!aborted) begin
            err_base = errors;
            for (int i = 0; i < 4 && !aborted; i++) begin
                step;
                dec_ack = 1'b0;
                flush = 1'b1;
                redirect_pc = $random(seed) & 32'hffff_fffc;
                exp_pc = redirect_pc;
                step;
                flush = 1'b0;
                run_words(12, 1'b1);
            end
            close_test(3, "redirect");
        end

        // Test 4 halts with a word held and ack high
        if (!aborted) begin
            err_base = errors;
            dec_ack = 1'b0;
            cyc = 0;
            while (!valid && cyc < WAIT_MAX) begin
                step;
                cyc++;
            end
            if (!valid) begin
                aborted = 1'b1;
                $display("t=%0t timeout waiting for a word before halt", $time);
            end else begin
                step;
                halt = 1'b1;
                dec_ack = 1'b1;
                hold_valid = valid;
                hold_instr = instr;
                hold_pc = pc;
                hold_watch = 1'b1;
                repeat (12) step;
                halt = 1'b0;
                hold_watch = 1'b0;
                run_words(20, 1'b1);
            end
            close_test(4, "halt");
        end

        // Test 5 runs loads side by side with fetch
        if (!aborted) begin
            err_base = errors;
            run_loads(12, 30);
            close_test(5, "concurrent loads");
        end

        $display("tests %0d, tests with errors %0d, checks %0d, errors %0d, timeout %0d",
                 tests_run, tests_bad, checks, errors, aborted);
        if (errors == 0 && tests_bad == 0 && !aborted)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* vlog.f */
src/fetch_pkg.sv
src/load_unit.sv
src/if_stage.sv
src/data_port.sv
src/wb_arbiter.sv
src/fetch_subsys_top.sv
sim/wb_mem_model.sv
sim/tb_fetch_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_fetch_subsys \
    -o tb_fetch_subsys

./obj_dir/tb_fetch_subsys | tee "$LOG"

if grep -qx "TEST PASS" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
